// File: hdl/druaga_pkg.sv
`default_nettype none

package druaga_pkg;

	// One byte from the host, address within the ROM map
	typedef struct packed {
		logic [16:0] addr;
		logic [7:0]  data;
	} rom_write_t;

	typedef enum logic [3:0] {
		REGION_CPU0    = 4'd0,
		REGION_SPCHIP0 = 4'd1,
		REGION_SPCHIP1 = 4'd2,
		REGION_CPU1    = 4'd3,
		REGION_BGCHIP  = 4'd4,
		REGION_SPCLUT  = 4'd5,
		REGION_BGCLUT  = 4'd6,
		REGION_WAVE    = 4'd7,
		REGION_PALET   = 4'd8,
		REGION_NONE    = 4'd9
	} rom_region_e;

	// Decoded write, offset relative to the region base
	typedef struct packed {
		rom_region_e region;
		logic [14:0] offset;
		logic [7:0]  data;
	} region_write_t;

	// ROM map, regions in ascending order
	localparam logic [16:0] CPU0_BASE    = 17'h00000;
	localparam logic [16:0] SPCHIP0_BASE = 17'h08000;
	localparam logic [16:0] SPCHIP1_BASE = 17'h0C000;
	localparam logic [16:0] CPU1_BASE    = 17'h10000;
	localparam logic [16:0] BGCHIP_BASE  = 17'h12000;
	localparam logic [16:0] SPCLUT_BASE  = 17'h13000;
	localparam logic [16:0] BGCLUT_BASE  = 17'h13400;
	localparam logic [16:0] WAVE_BASE    = 17'h13500;
	localparam logic [16:0] PALET_BASE   = 17'h13600;
	localparam logic [16:0] MAP_END      = 17'h13620;

	// Game model as reported by the host
	typedef enum logic [6:0] {
		MODEL_DRUAGA   = 7'd0,
		MODEL_DIGDUG2  = 7'd1,
		MODEL_MAPPY    = 7'd2,
		MODEL_VARIANT3 = 7'd3,
		MODEL_VARIANT4 = 7'd4,
		MODEL_MOTOS    = 7'd5,
		MODEL_GROBDA   = 7'd6
	} core_model_e;

	typedef struct packed {
		logic [7:0] dsw0;
		logic [7:0] dsw1;
		logic [7:0] dsw2;
	} dip_switches_t;

endpackage

`default_nettype wire

// File: hdl/download_capture.sv
`timescale 1ns/1ps
`default_nettype none

module download_capture (
	input  wire                    clock_48,
	input  wire                    arst_n,
	input  logic                   download,
	input  logic                   wr,
	input  logic [24:0]            addr,
	input  logic [7:0]             dout,
	output logic                   capture_valid,
	output druaga_pkg::rom_write_t capture,
	output logic                   download_done
);

	logic wr_q;
	logic download_q;
	logic write_pulse;

	// Rising strobe, only while a download is running
	assign write_pulse = wr & ~wr_q & download;

	always_ff @(posedge clock_48 or negedge arst_n) begin
		if (!arst_n) begin
			wr_q          <= 1'b0;
			download_q    <= 1'b0;
			capture_valid <= 1'b0;
			download_done <= 1'b0;
		end else begin
			wr_q          <= wr;
			download_q    <= download;
			capture_valid <= write_pulse;
			// End of download
			download_done <= download_q & ~download;
		end
	end

	// Byte and address as seen at the rising strobe
	always_ff @(posedge clock_48) begin
		if (write_pulse) begin
			capture.addr <= addr[16:0];
			capture.data <= dout;
		end
	end

endmodule

`default_nettype wire

// File: hdl/rom_region_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module rom_region_decoder (
	input  wire                       clock_48,
	input  wire                       arst_n,
	input  logic                      capture_valid,
	input  druaga_pkg::rom_write_t    capture,
	output logic                      region_valid,
	output druaga_pkg::region_write_t region_wr
);

	druaga_pkg::rom_region_e region;
	logic [16:0]             base;
	logic [16:0]             offset_full;

	// Highest base first, first match wins
	always_comb begin
		region = druaga_pkg::REGION_NONE;
		base   = druaga_pkg::CPU0_BASE;
		if (capture.addr >= druaga_pkg::MAP_END) begin
			region = druaga_pkg::REGION_NONE;
		end else if (capture.addr >= druaga_pkg::PALET_BASE) begin
			region = druaga_pkg::REGION_PALET;
			base   = druaga_pkg::PALET_BASE;
		end else if (capture.addr >= druaga_pkg::WAVE_BASE) begin
			region = druaga_pkg::REGION_WAVE;
			base   = druaga_pkg::WAVE_BASE;
		end else if (capture.addr >= druaga_pkg::BGCLUT_BASE) begin
			region = druaga_pkg::REGION_BGCLUT;
			base   = druaga_pkg::BGCLUT_BASE;
		end else if (capture.addr >= druaga_pkg::SPCLUT_BASE) begin
			region = druaga_pkg::REGION_SPCLUT;
			base   = druaga_pkg::SPCLUT_BASE;
		end else if (capture.addr >= druaga_pkg::BGCHIP_BASE) begin
			region = druaga_pkg::REGION_BGCHIP;
			base   = druaga_pkg::BGCHIP_BASE;
		end else if (capture.addr >= druaga_pkg::CPU1_BASE) begin
			region = druaga_pkg::REGION_CPU1;
			base   = druaga_pkg::CPU1_BASE;
		end else if (capture.addr >= druaga_pkg::SPCHIP1_BASE) begin
			region = druaga_pkg::REGION_SPCHIP1;
			base   = druaga_pkg::SPCHIP1_BASE;
		end else if (capture.addr >= druaga_pkg::SPCHIP0_BASE) begin
			region = druaga_pkg::REGION_SPCHIP0;
			base   = druaga_pkg::SPCHIP0_BASE;
		end else begin
			region = druaga_pkg::REGION_CPU0;
			base   = druaga_pkg::CPU0_BASE;
		end
	end

	// Largest region is 32k, so 15 bits hold any offset
	assign offset_full = capture.addr - base;

	always_ff @(posedge clock_48 or negedge arst_n) begin
		if (!arst_n) begin
			region_valid <= 1'b0;
		end else begin
			region_valid <= capture_valid && (region != druaga_pkg::REGION_NONE);
		end
	end

	always_ff @(posedge clock_48) begin
		if (capture_valid) begin
			region_wr.region <= region;
			region_wr.offset <= offset_full[14:0];
			region_wr.data   <= capture.data;
		end
	end

endmodule

`default_nettype wire

// File: hdl/rom_bank.sv
`timescale 1ns/1ps
`default_nettype none

module rom_bank #(
	parameter int                      ADDR_WIDTH  = 15,
	parameter druaga_pkg::rom_region_e BANK_REGION = druaga_pkg::REGION_CPU0
) (
	input  wire                       clock_48,
	input  logic                      region_valid,
	input  druaga_pkg::region_write_t region_wr,
	input  logic [ADDR_WIDTH-1:0]     rd_addr,
	output logic [7:0]                rd_data
);

	localparam int DEPTH = 2 ** ADDR_WIDTH;

	logic [7:0] mem [0:DEPTH-1];
	logic       wr_en;

	// Only writes decoded to this bank's region land here
	assign wr_en = region_valid && (region_wr.region == BANK_REGION);

	always_ff @(posedge clock_48) begin
		if (wr_en) begin
			mem[region_wr.offset[ADDR_WIDTH-1:0]] <= region_wr.data;
		end
	end

	// Read before write on a shared address
	always_ff @(posedge clock_48) begin
		rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

// File: hdl/core_reset_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module core_reset_sequencer (
	input  wire  clock_48,
	input  wire  arst_n,
	input  logic download,
	input  logic download_done,
	input  logic soft_reset,
	input  logic reset_button,
	output logic reset_core
);

	logic rom_loaded;
	logic rom_loaded_next;

	// Sticky once a full download has finished
	assign rom_loaded_next = rom_loaded | download_done;

	always_ff @(posedge clock_48 or negedge arst_n) begin
		if (!arst_n) begin
			rom_loaded <= 1'b0;
			reset_core <= 1'b1;
		end else begin
			rom_loaded <= rom_loaded_next;
			// Core stays in reset while loading or without ROM
			reset_core <= soft_reset | reset_button | download | ~rom_loaded_next;
		end
	end

endmodule

`default_nettype wire

// File: hdl/dip_switch_mapper.sv
`timescale 1ns/1ps
`default_nettype none

module dip_switch_mapper (
	input  wire                       clock_48,
	input  wire                       arst_n,
	input  logic [31:0]               status,
	input  logic [6:0]                core_mod,
	output druaga_pkg::dip_switches_t dip
);

	druaga_pkg::dip_switches_t dip_next;

	always_comb begin
		dip_next.dsw0 = status[15:8];
		dip_next.dsw1 = status[23:16];
		case (core_mod)
			druaga_pkg::MODEL_DRUAGA,
			druaga_pkg::MODEL_DIGDUG2,
			druaga_pkg::MODEL_VARIANT3,
			druaga_pkg::MODEL_GROBDA: begin
				dip_next.dsw2 = {status[19:16], status[27:24]};
			end
			druaga_pkg::MODEL_MAPPY: begin
				// Same nibble on both halves
				dip_next.dsw2 = {2{status[27:24]}};
			end
			default: begin
				dip_next.dsw2 = status[31:24];
			end
		endcase
	end

	always_ff @(posedge clock_48 or negedge arst_n) begin
		if (!arst_n) begin
			dip <= '0;
		end else begin
			dip <= dip_next;
		end
	end

endmodule

`default_nettype wire

// File: hdl/druaga_loader_top.sv
`timescale 1ns/1ps
`default_nettype none

module druaga_loader_top #(
	parameter int CPU_ADDR_WIDTH = 15,
	parameter int SND_ADDR_WIDTH = 13
) (
	input  wire                       clock_48,
	input  wire                       arst_n,
	input  logic                      download,
	input  logic                      wr,
	input  logic [24:0]               addr,
	input  logic [7:0]                dout,
	input  logic [31:0]               status,
	input  logic                      reset_button,
	input  logic [6:0]                core_mod,
	input  logic [CPU_ADDR_WIDTH-1:0] cpu_addr,
	output logic [7:0]                cpu_data,
	input  logic [SND_ADDR_WIDTH-1:0] snd_addr,
	output logic [7:0]                snd_data,
	output druaga_pkg::dip_switches_t dip,
	output logic                      reset_core
);

	logic                      capture_valid;
	druaga_pkg::rom_write_t    capture;
	logic                      download_done;
	logic                      region_valid;
	druaga_pkg::region_write_t region_wr;

	download_capture u_download_capture (
		.clock_48      (clock_48),
		.arst_n        (arst_n),
		.download      (download),
		.wr            (wr),
		.addr          (addr),
		.dout          (dout),
		.capture_valid (capture_valid),
		.capture       (capture),
		.download_done (download_done)
	);

	rom_region_decoder u_rom_region_decoder (
		.clock_48      (clock_48),
		.arst_n        (arst_n),
		.capture_valid (capture_valid),
		.capture       (capture),
		.region_valid  (region_valid),
		.region_wr     (region_wr)
	);

	// Main CPU program, 32k
	rom_bank #(
		.ADDR_WIDTH  (CPU_ADDR_WIDTH),
		.BANK_REGION (druaga_pkg::REGION_CPU0)
	) cpu_bank (
		.clock_48     (clock_48),
		.region_valid (region_valid),
		.region_wr    (region_wr),
		.rd_addr      (cpu_addr),
		.rd_data      (cpu_data)
	);

	// Sound CPU program, 8k
	rom_bank #(
		.ADDR_WIDTH  (SND_ADDR_WIDTH),
		.BANK_REGION (druaga_pkg::REGION_CPU1)
	) snd_bank (
		.clock_48     (clock_48),
		.region_valid (region_valid),
		.region_wr    (region_wr),
		.rd_addr      (snd_addr),
		.rd_data      (snd_data)
	);

	core_reset_sequencer u_core_reset_sequencer (
		.clock_48      (clock_48),
		.arst_n        (arst_n),
		.download      (download),
		.download_done (download_done),
		.soft_reset    (status[0]),
		.reset_button  (reset_button),
		.reset_core    (reset_core)
	);

	dip_switch_mapper u_dip_switch_mapper (
		.clock_48 (clock_48),
		.arst_n   (arst_n),
		.status   (status),
		.core_mod (core_mod),
		.dip      (dip)
	);

endmodule

`default_nettype wire

// File: verification/druaga_loader_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module druaga_loader_assertions (
	input  wire                       clock_48,
	input  wire                       arst_n,
	input  logic                      download,
	input  logic                      region_valid,
	input  druaga_pkg::region_write_t region_wr,
	input  logic                      reset_core
);

	// wr must drop between writes, so two valids never touch
	single_write_per_strobe: assert property (
		@(posedge clock_48) disable iff (!arst_n)
		region_valid |=> !region_valid
	) else $error("region_valid high for two cycles in a row");

	core_held_during_download: assert property (
		@(posedge clock_48) disable iff (!arst_n)
		download |=> reset_core
	) else $error("reset_core low in the cycle after download was high");

	valid_write_has_region: assert property (
		@(posedge clock_48) disable iff (!arst_n)
		region_valid |-> (region_wr.region != druaga_pkg::REGION_NONE)
	) else $error("region_valid high with no region decoded");

endmodule

bind druaga_loader_top druaga_loader_assertions u_assertions (
	.clock_48     (clock_48),
	.arst_n       (arst_n),
	.download     (download),
	.region_valid (region_valid),
	.region_wr    (region_wr),
	.reset_core   (reset_core)
);

`default_nettype wire

// File: verification/druaga_loader_tb.sv
`timescale 1ns/1ps
`default_nettype none

module druaga_loader_tb;

	// Tests run for a few hundred cycles
	localparam int TIMEOUT_CYCLES = 4000;

	logic                      clock_48;
	logic                      arst_n;
	logic                      download;
	logic                      wr;
	logic [24:0]               addr;
	logic [7:0]                dout;
	logic [31:0]               status;
	logic                      reset_button;
	logic [6:0]                core_mod;
	logic [14:0]               cpu_addr;
	logic [7:0]                cpu_data;
	logic [12:0]               snd_addr;
	logic [7:0]                snd_data;
	druaga_pkg::dip_switches_t dip;
	logic                      reset_core;

	logic [31:0] lfsr;
	logic [7:0]  cpu_model [0:15];
	logic [7:0]  snd_model [0:15];
	int          error_count;
	int          check_count;
	int          cycle_count = 0;

	druaga_loader_top #(
		.CPU_ADDR_WIDTH (15),
		.SND_ADDR_WIDTH (13)
	) DUT (
		.clock_48     (clock_48),
		.arst_n       (arst_n),
		.download     (download),
		.wr           (wr),
		.addr         (addr),
		.dout         (dout),
		.status       (status),
		.reset_button (reset_button),
		.core_mod     (core_mod),
		.cpu_addr     (cpu_addr),
		.cpu_data     (cpu_data),
		.snd_addr     (snd_addr),
		.snd_data     (snd_data),
		.dip          (dip),
		.reset_core   (reset_core)
	);

	initial begin
		clock_48 = 1'b0;
		forever #5 clock_48 = ~clock_48;
	end

	always @(posedge clock_48) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Run timed out after %0d cycles", cycle_count);
			$display("Simulation FAILED");
			$finish;
		end
	end

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	task automatic random_bits(input int count, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsr  = lfsr_next(lfsr);
			value = {value[30:0], lfsr[0]};
		end
	endtask

	task automatic random_byte(output logic [7:0] value);
		logic [31:0] bits;
		random_bits(8, bits);
		value = bits[7:0];
	endtask

	function automatic druaga_pkg::dip_switches_t expected_dip(input logic [31:0] word,
		input logic [6:0] model);
		druaga_pkg::dip_switches_t result;
		result.dsw0 = word[15:8];
		result.dsw1 = word[23:16];
		if (model == 7'd0 || model == 7'd1 || model == 7'd3 || model == 7'd6) begin
			result.dsw2 = {word[19:16], word[27:24]};
		end else if (model == 7'd2) begin
			result.dsw2 = {word[27:24], word[27:24]};
		end else begin
			result.dsw2 = word[31:24];
		end
		return result;
	endfunction

	task automatic check_byte(input logic [7:0] actual, input logic [7:0] expected,
		input string what);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("CHECK FAILED at time %0t: %s, got %02h, expected %02h",
				$time, what, actual, expected);
		end
	endtask

	task automatic check_dip(input druaga_pkg::dip_switches_t actual,
		input druaga_pkg::dip_switches_t expected, input string what);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("CHECK FAILED at time %0t: %s, got %06h, expected %06h",
				$time, what, actual, expected);
		end
	endtask

	task automatic check_bit(input logic actual, input logic expected, input string what);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("CHECK FAILED at time %0t: %s, got %b, expected %b",
				$time, what, actual, expected);
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		if (error_count == errors_before) begin
			$display("%s: ok", name);
		end else begin
			$display("%s: %0d errors", name, error_count - errors_before);
		end
	endtask

	// Strobe held two cycles and room left for capture, decode and write
	task automatic download_byte(input logic [16:0] rom_addr, input logic [7:0] value);
		addr = {8'h00, rom_addr};
		dout = value;
		wr   = 1'b1;
		repeat (2) @(negedge clock_48);
		wr = 1'b0;
		repeat (4) @(negedge clock_48);
	endtask

	task automatic verify_banks(input string when);
		for (int i = 0; i < 16; i++) begin
			cpu_addr = 15'(i);
			snd_addr = 13'(i);
			@(negedge clock_48);
			check_byte(cpu_data, cpu_model[i], $sformatf("%s, cpu byte %0d", when, i));
			check_byte(snd_data, snd_model[i], $sformatf("%s, sound byte %0d", when, i));
		end
	endtask

	task automatic test_reset_state();
		int errors_before;
		errors_before = error_count;
		check_bit(reset_core, 1'b1, "reset_core after reset");
		check_dip(dip, '0, "dip after reset");
		repeat (2) @(negedge clock_48);
		check_bit(reset_core, 1'b1, "reset_core without ROM");
		check_dip(dip, expected_dip(status, core_mod), "dip once status is sampled");
		status = '0;
		@(negedge clock_48);
		check_dip(dip, '0, "dip after status clears");
		report_test("reset_state", errors_before);
	endtask

	task automatic test_rom_loading();
		int         errors_before;
		logic [7:0] value;
		errors_before = error_count;
		download = 1'b1;
		@(negedge clock_48);
		for (int i = 0; i < 16; i++) begin
			random_byte(value);
			cpu_model[i] = value;
			download_byte(druaga_pkg::CPU0_BASE + 17'(i), value);
		end
		for (int i = 0; i < 16; i++) begin
			random_byte(value);
			snd_model[i] = value;
			download_byte(druaga_pkg::CPU1_BASE + 17'(i), value);
		end
		check_bit(reset_core, 1'b1, "reset_core during download");
		verify_banks("after load");
		report_test("rom_loading", errors_before);
	endtask

	task automatic test_region_isolation();
		int         errors_before;
		logic [7:0] value;
		errors_before = error_count;
		for (int i = 0; i < 4; i++) begin
			random_byte(value);
			download_byte(druaga_pkg::SPCHIP0_BASE + 17'(i), value);
			random_byte(value);
			download_byte(druaga_pkg::BGCHIP_BASE + 17'(i), value);
			random_byte(value);
			download_byte(druaga_pkg::PALET_BASE + 17'(i), value);
			random_byte(value);
			download_byte(druaga_pkg::MAP_END + 17'(i), value);
		end
		verify_banks("after other regions");
		report_test("region_isolation", errors_before);
	endtask

	task automatic test_strobe_filtering();
		int         errors_before;
		logic [7:0] value;
		logic [7:0] first_byte;
		errors_before = error_count;
		download = 1'b0;
		@(negedge clock_48);
		random_byte(value);
		download_byte(druaga_pkg::CPU0_BASE + 17'd3, value);
		random_byte(value);
		download_byte(druaga_pkg::CPU1_BASE + 17'd3, value);
		verify_banks("after strobes without download");
		download = 1'b1;
		@(negedge clock_48);
		random_byte(first_byte);
		addr = {8'h00, druaga_pkg::CPU0_BASE + 17'd5};
		dout = first_byte;
		wr   = 1'b1;
		repeat (3) @(negedge clock_48);
		// Data moves while the strobe is still high
		dout = ~first_byte;
		repeat (3) @(negedge clock_48);
		wr = 1'b0;
		repeat (4) @(negedge clock_48);
		cpu_model[5] = first_byte;
		verify_banks("after held strobe");
		report_test("strobe_filtering", errors_before);
	endtask

	task automatic test_reset_sequencing();
		int errors_before;
		errors_before = error_count;
		download = 1'b0;
		repeat (2) @(negedge clock_48);
		check_bit(reset_core, 1'b0, "reset_core after download ends");
		status[0] = 1'b1;
		@(negedge clock_48);
		check_bit(reset_core, 1'b1, "reset_core with status bit 0");
		status[0] = 1'b0;
		@(negedge clock_48);
		check_bit(reset_core, 1'b0, "reset_core after status bit 0 drops");
		reset_button = 1'b1;
		@(negedge clock_48);
		check_bit(reset_core, 1'b1, "reset_core with reset button");
		reset_button = 1'b0;
		@(negedge clock_48);
		check_bit(reset_core, 1'b0, "reset_core after reset button drops");
		download = 1'b1;
		for (int i = 0; i < 8; i++) begin
			@(negedge clock_48);
			check_bit(reset_core, 1'b1, "reset_core during new download");
		end
		download = 1'b0;
		repeat (2) @(negedge clock_48);
		check_bit(reset_core, 1'b0, "reset_core after new download");
		report_test("reset_sequencing", errors_before);
	endtask

	task automatic test_dip_mapping();
		int          errors_before;
		logic [31:0] word;
		logic [6:0]  models [0:2] = '{7'd0, 7'd2, 7'd5};
		errors_before = error_count;
		for (int i = 0; i < 3; i++) begin
			random_bits(32, word);
			status   = word;
			core_mod = models[i];
			@(negedge clock_48);
			check_dip(dip, expected_dip(word, models[i]),
				$sformatf("dip for model %0d", models[i]));
		end
		report_test("dip_mapping", errors_before);
	endtask

	initial begin
		download     = 1'b0;
		wr           = 1'b0;
		addr         = '0;
		dout         = '0;
		// Nonzero status while in reset, bit 0 clear
		status       = 32'hc3a5_5a3c;
		reset_button = 1'b0;
		core_mod     = '0;
		cpu_addr     = '0;
		snd_addr     = '0;
		arst_n       = 1'b0;
		lfsr         = 32'h2be5;
		error_count  = 0;
		check_count  = 0;
		repeat (5) @(posedge clock_48);
		@(negedge clock_48);
		arst_n = 1'b1;

		test_reset_state();
		test_rom_loading();
		test_region_isolation();
		test_strobe_filtering();
		test_reset_sequencing();
		test_dip_mapping();

		$display("%0d checks, %0d errors", check_count, error_count);
		if (error_count == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: druaga_loader_top.f
hdl/druaga_pkg.sv
hdl/download_capture.sv
hdl/rom_region_decoder.sv
hdl/rom_bank.sv
hdl/core_reset_sequencer.sv
hdl/dip_switch_mapper.sv
hdl/druaga_loader_top.sv
verification/druaga_loader_assertions.sv
verification/druaga_loader_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module druaga_loader_tb \
	-f druaga_loader_top.f \
	-o druaga_loader_sim

./obj_dir/druaga_loader_sim | tee sim.log

if grep -qx "Simulation PASSED" sim.log; then
	echo "Run passed"
	exit 0
else
	echo "Run failed"
	exit 1
fi
